// ==== verilog/gfx_pkg.sv ====
package gfx_pkg;

    // ----------------------------------------------------------
    // screen and pixel formats
    // ----------------------------------------------------------

    localparam int screen_width  = 640;
    localparam int screen_height = 480;

    localparam int w_coord = 10;                  // x, y and geometry, wraps at 1024

    localparam int w_red   = 4;
    localparam int w_green = 4;
    localparam int w_blue  = 4;
    localparam int w_rgb   = w_red + w_green + w_blue;

    typedef logic [w_coord - 1:0] coord_t;
    typedef logic [w_rgb   - 1:0] rgb_t;          // red in msbs, blue in lsbs

    // ----------------------------------------------------------
    // shape kinds and axis select
    // ----------------------------------------------------------

    typedef enum logic [2:0]
    {
        square,                                   // both ramps nonzero
        rhomb,                                    // ramp x against ry - ramp y
        eye,                                      // sine x against ry - ramp y
        eye_vert,                                 // ramp x against ry - sine y
        circle                                    // sine x against ry - sine y
    } shape_e;

    typedef enum logic
    {
        axis_x,
        axis_y
    } axis_e;

    // dark grey, lsb set in every channel
    localparam rgb_t bg_color =
    {
        {(w_red   - 1) {1'b0}}, 1'b1,
        {(w_green - 1) {1'b0}}, 1'b1,
        {(w_blue  - 1) {1'b0}}, 1'b1
    };

endpackage

// ==== verilog/scene_pkg.sv ====
package scene_pkg;

    import gfx_pkg::*;

    localparam int n_shapes = 16;

    // ----------------------------------------------------------
    // geometry rules, all 10-bit modulo
    // ----------------------------------------------------------
    //
    // ramp t of coordinate z against offset m and radius r:
    //   m      <= z <  m + r   :  t = z - m
    //   m + r  <= z <= m + 2r  :  t = m + 2r - z
    //   otherwise              :  t = 0
    //
    // sine s of ramp t against radius r, shift-add segments:
    //   t < 0.4375 r  :  s = t + t/2 - t/32
    //   t < 0.625  r  :  s = t - t/8 + r/4
    //   t < 0.8125 r  :  s = t/2 + t/32 + r/2 - r/32
    //   otherwise     :  s = t/8 + t/16 + r - r/4 - r/32
    //
    // a shape spans mx .. mx + 2rx and my .. my + 2ry

    // ----------------------------------------------------------
    // palette
    // ----------------------------------------------------------

    localparam rgb_t c_red     = {{w_red {1'b1}}, {w_green {1'b0}}, {w_blue {1'b0}}};
    localparam rgb_t c_green   = {{w_red {1'b0}}, {w_green {1'b1}}, {w_blue {1'b0}}};
    localparam rgb_t c_blue    = {{w_red {1'b0}}, {w_green {1'b0}}, {w_blue {1'b1}}};
    localparam rgb_t c_magenta = {{w_red {1'b1}}, {w_green {1'b0}}, {w_blue {1'b1}}};
    localparam rgb_t c_yellow  = {{w_red {1'b1}}, {w_green {1'b1}}, {w_blue {1'b0}}};
    localparam rgb_t c_cyan    = {{w_red {1'b0}}, {w_green {1'b1}}, {w_blue {1'b1}}};

    // ----------------------------------------------------------
    // scene table, shape 15 first, higher index on top
    // ----------------------------------------------------------

    localparam coord_t shape_mx [n_shapes - 1:0] = '{
         30, 100, 330, 330, 130, 230, 330, 430,
        100, 630, 650, 430, 530, 130,  30, 530 };

    localparam coord_t shape_my [n_shapes - 1:0] = '{
         30,  70,  30, 330, 130, 230, 330, 230,
        330, 230,  30, 130, 130,  30, 230, 330 };

    localparam coord_t shape_rx [n_shapes - 1:0] = '{
         50,  50,  80,  40, 120,  50,  50,  50,
        370,  50,  50,  70,  50,  50,  80,  60 };   // shape 7 is the long bar

    localparam coord_t shape_ry [n_shapes - 1:0] = '{
         50,  50,  80,  40, 120,  50,  50,  50,
         10,  50,  50,  70,  50,  50,  80,  60 };

    localparam shape_e shape_kind [n_shapes - 1:0] = '{
        square, circle, eye,      circle, circle, square, square, square,
        square, eye_vert, rhomb,  circle, rhomb,  rhomb,  circle, circle };

    localparam rgb_t shape_color [n_shapes - 1:0] = '{
        c_red,   c_green, c_blue, c_magenta, c_yellow, c_magenta, c_cyan,    c_red,
        c_green, c_blue,  c_red,  c_green,   c_blue,   c_magenta, c_red,     c_magenta };

endpackage

// ==== verilog/profile_if.sv ====
`timescale 1ns/1ps

// per-shape profile of one axis, one pixel per cycle
interface profile_if
    import gfx_pkg::*, scene_pkg::*;
();

    coord_t [n_shapes - 1:0] ramp;                // triangular ramp per shape
    coord_t [n_shapes - 1:0] sine;                // sine-bent ramp per shape
    logic                    valid;

    // ----------------------------------------------------------
    // producer and consumer views
    // ----------------------------------------------------------

    modport src
    (
        output ramp,
        output sine,
        output valid
    );

    modport dst
    (
        input  ramp,
        input  sine,
        input  valid
    );

endinterface

// ==== verilog/axis_profile.sv ====
`timescale 1ns/1ps

module axis_profile
    import gfx_pkg::*, scene_pkg::*;
#(
    parameter axis_e axis = axis_x
)
(
    input                clk,
    input                rst,
    input  [w_coord - 1:0] coord,
    input                coord_valid,
    profile_if.src       prof
);

    coord_t [n_shapes - 1:0] ramp_next;
    coord_t [n_shapes - 1:0] sine_next;

    // ----------------------------------------------------------
    // triangle over m .. m + 2r, peak r at m + r
    // ----------------------------------------------------------

    function automatic coord_t ramp_of(input coord_t z, input coord_t m, input coord_t r);
        coord_t mid;
        coord_t top;
        coord_t t;
        mid = m + r;
        top = m + (r << 1);                       // wraps like the coordinates
        if ((z >= m) && (z < mid))
            t = z - m;
        else if ((z >= mid) && (z <= top))
            t = top - z;
        else
            t = '0;
        return t;
    endfunction

    // ----------------------------------------------------------
    // bend the triangle toward a sine envelope
    // ----------------------------------------------------------

    function automatic coord_t sine_of(input coord_t t, input coord_t r);
        coord_t b0;
        coord_t b1;
        coord_t b2;
        coord_t s;
        b0 = (r >> 1) - (r >> 4);                 // 0.4375 r
        b1 = (r >> 1) + (r >> 3);                 // 0.625 r
        b2 = (r >> 1) + (r >> 2) + (r >> 4);      // 0.8125 r
        if (t < b0)
            s = t + (t >> 1) - (t >> 5);          // steep start
        else if (t < b1)
            s = t - (t >> 3) + (r >> 2);
        else if (t < b2)
            s = (t >> 1) + (t >> 5) + (r >> 1) - (r >> 5);
        else
            s = (t >> 3) + (t >> 4) + r - (r >> 2) - (r >> 5);  // flat top
        return s;
    endfunction

    always_comb
    begin
        for (int i = 0; i < n_shapes; i++)
        begin
            if (axis == axis_x)
                ramp_next[i] = ramp_of(coord, shape_mx[i], shape_rx[i]);
            else
                ramp_next[i] = ramp_of(coord, shape_my[i], shape_ry[i]);

            if (axis == axis_x)
                sine_next[i] = sine_of(ramp_next[i], shape_rx[i]);
            else
                sine_next[i] = sine_of(ramp_next[i], shape_ry[i]);
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            prof.valid <= 1'b0;
        else
            prof.valid <= coord_valid;

        if (coord_valid)                          // hold profile between pixels
        begin
            prof.ramp <= ramp_next;
            prof.sine <= sine_next;
        end
    end

endmodule

// ==== verilog/shape_cover.sv ====
`timescale 1ns/1ps

module shape_cover
    import gfx_pkg::*, scene_pkg::*;
(
    input                      clk,
    input                      rst,
    profile_if.dst             px,
    profile_if.dst             py,
    output logic [w_red   - 1:0] red,
    output logic [w_green - 1:0] green,
    output logic [w_blue  - 1:0] blue,
    output logic               rgb_valid
);

    logic [n_shapes - 1:0] covered;               // one flag per shape
    rgb_t                  rgb_next;
    rgb_t                  rgb_q;

    // ----------------------------------------------------------
    // coverage test of one shape kind
    // ----------------------------------------------------------

    function automatic logic cover_test
    (
        input shape_e kind,
        input coord_t tx,
        input coord_t sx,
        input coord_t ty,
        input coord_t sy,
        input coord_t ry
    );
        logic hit;
        case (kind)
            square:
                hit = (tx != '0) && (ty != '0);
            rhomb:
                hit = (tx >= coord_t'(ry - ty)) && (tx != '0) && (ty != '0);
            eye:
                hit = (sx >= coord_t'(ry - ty)) && (sx != '0) && (sy != '0);
            eye_vert:
                hit = (tx >= coord_t'(ry - sy)) && (sx != '0) && (sy != '0);
            circle:
                hit = (sx >= coord_t'(ry - sy)) && (sx != '0) && (sy != '0);
            default:
                hit = 1'b0;                       // unused encodings
        endcase
        return hit;
    endfunction

    always_comb
    begin
        for (int i = 0; i < n_shapes; i++)
        begin
            covered[i] = cover_test(shape_kind[i],
                                    px.ramp[i], px.sine[i],
                                    py.ramp[i], py.sine[i],
                                    shape_ry[i]);
        end
    end

    // ----------------------------------------------------------
    // priority pick, later index overrides
    // ----------------------------------------------------------

    always_comb
    begin
        rgb_next = bg_color;
        for (int i = 0; i < n_shapes; i++)
        begin
            if (covered[i])
                rgb_next = shape_color[i];        // shape 15 ends on top
        end
    end

    // x and y profiles are sampled together, px.valid stands for both
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rgb_valid <= 1'b0;
            rgb_q     <= '0;
        end
        else
        begin
            rgb_valid <= px.valid;
            if (px.valid)
                rgb_q <= rgb_next;
        end
    end

    assign red   = rgb_q[w_rgb - 1           -: w_red  ];
    assign green = rgb_q[w_green + w_blue - 1 -: w_green];
    assign blue  = rgb_q[0                    +: w_blue ];

endmodule

// ==== verilog/shape_render.sv ====
`timescale 1ns/1ps

module shape_render
    import gfx_pkg::*;
(
    input                      clk,
    input                      rst,

    // pixel coordinate stream
    input        [w_coord - 1:0] x,
    input        [w_coord - 1:0] y,
    input                      pix_valid,

    // colour stream, two cycles later
    output logic [w_red   - 1:0] red,
    output logic [w_green - 1:0] green,
    output logic [w_blue  - 1:0] blue,
    output logic               rgb_valid
);

    profile_if prof_x ();
    profile_if prof_y ();

    // ----------------------------------------------------------
    // stage 1, per-axis profiles
    // ----------------------------------------------------------

    axis_profile #(.axis(axis_x)) prof_x_inst
    (
        .clk         (clk),
        .rst         (rst),
        .coord       (x),
        .coord_valid (pix_valid),
        .prof        (prof_x)
    );

    axis_profile #(.axis(axis_y)) prof_y_inst
    (
        .clk         (clk),
        .rst         (rst),
        .coord       (y),
        .coord_valid (pix_valid),
        .prof        (prof_y)
    );

    // ----------------------------------------------------------
    // stage 2, coverage and colour
    // ----------------------------------------------------------

    shape_cover cover_inst
    (
        .clk       (clk),
        .rst       (rst),
        .px        (prof_x),
        .py        (prof_y),
        .red       (red),
        .green     (green),
        .blue      (blue),
        .rgb_valid (rgb_valid)
    );

endmodule

// ==== bench/shape_render_assert.sv ====
`timescale 1ns/1ps

module shape_render_assert
    import gfx_pkg::*;
(
    input                 clk,
    input                 rst,
    input                 pix_valid,
    input                 rgb_valid,
    input [w_red   - 1:0] red,
    input [w_green - 1:0] green,
    input [w_blue  - 1:0] blue
);

    localparam int latency = 2;

    // ----------------------------------------------------------
    // stream timing
    // ----------------------------------------------------------

    property valid_follows_pixel;
        @(posedge clk) disable iff (rst)
        rgb_valid == $past(pix_valid, latency);
    endproperty

    property quiet_in_reset;
        @(posedge clk)
        rst |=> !rgb_valid;
    endproperty

    // ----------------------------------------------------------
    // output values
    // ----------------------------------------------------------

    property colour_known;
        @(posedge clk) disable iff (rst)
        rgb_valid |-> !$isunknown({red, green, blue});
    endproperty

    assert property (valid_follows_pixel)
    else
        $error("rgb_valid is not pix_valid delayed by two cycles");

    assert property (quiet_in_reset)
    else
        $error("rgb_valid high during reset or on the cycle after");

    assert property (colour_known)
    else
        $error("colour has unknown bits while rgb_valid is high");

endmodule

bind shape_render shape_render_assert shape_render_assert_inst
(
    .clk       (clk),
    .rst       (rst),
    .pix_valid (pix_valid),
    .rgb_valid (rgb_valid),
    .red       (red),
    .green     (green),
    .blue      (blue)
);

// ==== bench/tb_shape_render.sv ====
`timescale 1ns/1ps

module tb_shape_render
    import gfx_pkg::*, scene_pkg::*;
();

    localparam int clk_half       = 4;            // 8 ns period
    localparam int drive_skew     = 1;
    localparam int reset_cycles   = 3;
    localparam int latency        = 2;
    localparam int n_rows         = 16;
    localparam int n_random       = 400;          // random cycles after the table
    localparam int timeout_cycles = 2 * n_rows + n_random + 20;
    localparam int coord_mask     = (1 << w_coord) - 1;

    typedef struct packed
    {
        coord_t     x;
        coord_t     y;
        logic [1:0] gap;                          // idle cycles before the pixel
        rgb_t       rgb;
    } stim_row_t;

    // ----------------------------------------------------------
    // directed pixels and their colours
    // ----------------------------------------------------------

    localparam stim_row_t stim_table [n_rows] = '{
        '{10'd5,   10'd470, 2'd0, 12'h111},      // outside every shape
        '{10'd80,  10'd80,  2'd0, 12'hf00},      // square 15 centre
        '{10'd580, 10'd180, 2'd0, 12'h00f},      // rhomb 3 centre
        '{10'd410, 10'd110, 2'd1, 12'h00f},      // eye 13 centre
        '{10'd680, 10'd280, 2'd0, 12'h00f},      // vertical eye 6 centre
        '{10'd150, 10'd120, 2'd0, 12'h0f0},      // circle 14 centre
        '{10'd540, 10'd140, 2'd1, 12'h111},      // rhomb 3 corner is empty
        '{10'd195, 10'd165, 2'd0, 12'hff0},      // circle 14 corner shows 11
        '{10'd380, 10'd380, 2'd0, 12'hf0f},      // circle 12 over square 9
        '{10'd420, 10'd420, 2'd1, 12'h0ff},      // square 9 alone
        '{10'd340, 10'd340, 2'd0, 12'h0ff},      // square 9 over bar 7
        '{10'd180, 10'd80,  2'd0, 12'hf0f},      // rhomb 2 centre
        '{10'd129, 10'd80,  2'd1, 12'hf00},      // last column of square 15
        '{10'd130, 10'd80,  2'd0, 12'h0f0},      // edge of 15 falls to 14
        '{10'd590, 10'd390, 2'd0, 12'hf0f},      // circle 0 centre
        '{10'd110, 10'd310, 2'd1, 12'hf00}       // circle 1 centre
    };

    logic                 clk;
    logic                 rst;
    coord_t               x;
    coord_t               y;
    logic                 pix_valid;
    logic [w_red   - 1:0] red;
    logic [w_green - 1:0] green;
    logic [w_blue  - 1:0] blue;
    logic                 rgb_valid;

    int     cycle         = 0;
    int     issued_count  = 0;
    int     checked_count = 0;
    rgb_t   expect_q [$];                         // colours in flight
    int     due_q    [$];                         // cycle each colour is due
    coord_t x_q      [$];
    coord_t y_q      [$];

    shape_render shape_render_inst
    (
        .clk       (clk),
        .rst       (rst),
        .x         (x),
        .y         (y),
        .pix_valid (pix_valid),
        .red       (red),
        .green     (green),
        .blue      (blue),
        .rgb_valid (rgb_valid)
    );

    initial clk = 1'b0;
    always #clk_half clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
        if (cycle >= timeout_cycles)
            report_failure($sformatf("timeout after %0d cycles with pixels still pending",
                                     timeout_cycles));
    end

    // ----------------------------------------------------------
    // reference model of the scene
    // ----------------------------------------------------------

    function automatic int wrap(input int v);
        return v & coord_mask;
    endfunction

    function automatic int ramp_value(input int z, input int m, input int r);
        int rise_end;
        int fall_end;
        rise_end = wrap(m + r);
        fall_end = wrap(m + 2 * r);
        if ((z >= m) && (z < rise_end))
            return wrap(z - m);
        if ((z >= rise_end) && (z <= fall_end))
            return wrap(fall_end - z);
        return 0;
    endfunction

    function automatic int sine_value(input int t, input int r);
        int knee0;
        int knee1;
        int knee2;
        knee0 = wrap(r / 2 - r / 16);
        knee1 = wrap(r / 2 + r / 8);
        knee2 = wrap(r / 2 + r / 4 + r / 16);
        if (t < knee0)
            return wrap(t + t / 2 - t / 32);
        if (t < knee1)
            return wrap(t - t / 8 + r / 4);
        if (t < knee2)
            return wrap(t / 2 + t / 32 + r / 2 - r / 32);
        return wrap(t / 8 + t / 16 + r - r / 4 - r / 32);
    endfunction

    function automatic bit covers_pixel(input int i, input int px, input int py);
        int tx;
        int ty;
        int sx;
        int sy;
        int ry;
        tx = ramp_value(px, int'(shape_mx[i]), int'(shape_rx[i]));
        ty = ramp_value(py, int'(shape_my[i]), int'(shape_ry[i]));
        sx = sine_value(tx, int'(shape_rx[i]));
        sy = sine_value(ty, int'(shape_ry[i]));
        ry = int'(shape_ry[i]);
        case (shape_kind[i])
            square:
                return (tx != 0) && (ty != 0);
            rhomb:
                return (tx >= wrap(ry - ty)) && (tx != 0) && (ty != 0);
            eye:
                return (sx >= wrap(ry - ty)) && (sx != 0) && (sy != 0);
            eye_vert:
                return (tx >= wrap(ry - sy)) && (sx != 0) && (sy != 0);
            circle:
                return (sx >= wrap(ry - sy)) && (sx != 0) && (sy != 0);
            default:
                return 1'b0;
        endcase
    endfunction

    function automatic rgb_t expected_color(input int px, input int py);
        for (int i = n_shapes - 1; i >= 0; i--)
        begin
            if (covers_pixel(i, px, py))          // first hit from the top
                return shape_color[i];
        end
        return bg_color;
    endfunction

    // ----------------------------------------------------------
    // pixel driver
    // ----------------------------------------------------------

    task automatic drive_pixel(input coord_t px, input coord_t py, input rgb_t rgb);
        @(posedge clk);
        #drive_skew;
        x         = px;
        y         = py;
        pix_valid = 1'b1;
        expect_q.push_back(rgb);
        due_q.push_back(cycle + latency);
        x_q.push_back(px);
        y_q.push_back(py);
        issued_count++;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #drive_skew;
        x         = coord_t'($urandom % screen_width);   // ignored by the DUT
        y         = coord_t'($urandom % screen_height);
        pix_valid = 1'b0;
    endtask

    // ----------------------------------------------------------
    // output monitor
    // ----------------------------------------------------------

    task automatic check_output();
        rgb_t   want;
        int     due;
        coord_t px;
        coord_t py;
        assert (expect_q.size() != 0)
        else
            report_failure("rgb_valid went high with no pixel in flight");
        want = expect_q.pop_front();
        due  = due_q.pop_front();
        px   = x_q.pop_front();
        py   = y_q.pop_front();
        assert (due == cycle)
        else
            report_failure($sformatf("ERROR rgb_valid: due at cycle 0x%h, seen at cycle 0x%h",
                                     due, cycle));
        assert ({red, green, blue} == want)
        else
            report_failure($sformatf("ERROR {red,green,blue}: expected 0x%h, got 0x%h (x %0d y %0d)",
                                     want, {red, green, blue}, px, py));
        checked_count++;
    endtask

    always @(negedge clk)
    begin
        if (!rst)
        begin
            assert (!$isunknown(rgb_valid))
            else
                report_failure("rgb_valid is unknown after reset");
            if (rgb_valid)
                check_output();
            else if (due_q.size() != 0)
            begin
                assert (due_q[0] > cycle)         // a gap must not swallow a pixel
                else
                    report_failure("rgb_valid stayed low when a pixel was due");
            end
        end
        else
        begin
            assert (rgb_valid !== 1'b1)
            else
                report_failure("rgb_valid went high during reset");
        end
    end

    // ----------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------

    initial
    begin
        coord_t rand_x;
        coord_t rand_y;
        rgb_t   model_rgb;

        void'($urandom(32'h40d5));
        rst       = 1'b1;
        pix_valid = 1'b0;
        x         = '0;
        y         = '0;

        repeat (reset_cycles) @(posedge clk);
        #drive_skew;
        rst = 1'b0;

        for (int row = 0; row < n_rows; row++)
        begin
            model_rgb = expected_color(int'(stim_table[row].x), int'(stim_table[row].y));
            assert (stim_table[row].rgb == model_rgb)
            else
                report_failure($sformatf("ERROR table row %0d rgb: table 0x%h, model 0x%h",
                                         row, stim_table[row].rgb, model_rgb));
            repeat (stim_table[row].gap) idle_cycle();
            drive_pixel(stim_table[row].x, stim_table[row].y, stim_table[row].rgb);
        end

        for (int n = 0; n < n_random; n++)
        begin
            rand_x = coord_t'($urandom % screen_width);
            rand_y = coord_t'($urandom % screen_height);
            if (($urandom % 4) != 0)              // about three in four cycles busy
                drive_pixel(rand_x, rand_y, expected_color(int'(rand_x), int'(rand_y)));
            else
                idle_cycle();
        end

        idle_cycle();
        while (expect_q.size() != 0)
            @(posedge clk);
        repeat (latency) @(posedge clk);

        if ((checked_count == issued_count) && (checked_count > 0))
        begin
            $display("=== PASS ===");
            $finish;
        end
        else
            report_failure($sformatf("only %0d of %0d pixels were checked",
                                     checked_count, issued_count));
    end

endmodule

// ==== shape_render.f ====
verilog/gfx_pkg.sv
verilog/scene_pkg.sv
verilog/profile_if.sv
verilog/axis_profile.sv
verilog/shape_cover.sv
verilog/shape_render.sv
bench/shape_render_assert.sv
bench/tb_shape_render.sv

// ==== Makefile ====
TOOL     = verilator
TOP      = tb_shape_render
FILELIST = shape_render.f
FLAGS    = --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP)
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = === PASS ===

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with $(TOOL), run $(TOP), search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD) and $(LOG)"

test:
	$(TOOL) $(FLAGS) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
